//--- verilog/decode_pkg.sv
package decode_pkg;

    localparam int instr_w = 32;
    localparam int op_w    = 6;
    localparam int funct_w = 6;
    localparam int rt_w    = 5;

    // Primary opcodes, instr[31:26]
    localparam logic [op_w-1:0] op_special = 6'b000000;
    localparam logic [op_w-1:0] op_regimm  = 6'b000001;
    localparam logic [op_w-1:0] op_j       = 6'b000010;
    localparam logic [op_w-1:0] op_jal     = 6'b000011;
    localparam logic [op_w-1:0] op_beq     = 6'b000100;
    localparam logic [op_w-1:0] op_bne     = 6'b000101;
    localparam logic [op_w-1:0] op_blez    = 6'b000110;
    localparam logic [op_w-1:0] op_bgtz    = 6'b000111;
    localparam logic [op_w-1:0] op_addi    = 6'b001000;
    localparam logic [op_w-1:0] op_addiu   = 6'b001001;
    localparam logic [op_w-1:0] op_slti    = 6'b001010;
    localparam logic [op_w-1:0] op_sltiu   = 6'b001011;
    localparam logic [op_w-1:0] op_andi    = 6'b001100;
    localparam logic [op_w-1:0] op_ori     = 6'b001101;
    localparam logic [op_w-1:0] op_xori    = 6'b001110;
    localparam logic [op_w-1:0] op_lui     = 6'b001111;
    localparam logic [op_w-1:0] op_lb      = 6'b100000;
    localparam logic [op_w-1:0] op_lh      = 6'b100001;
    localparam logic [op_w-1:0] op_lw      = 6'b100011;
    localparam logic [op_w-1:0] op_lbu     = 6'b100100;
    localparam logic [op_w-1:0] op_lhu     = 6'b100101;
    localparam logic [op_w-1:0] op_sb      = 6'b101000;
    localparam logic [op_w-1:0] op_sh      = 6'b101001;
    localparam logic [op_w-1:0] op_sw      = 6'b101011;

    // SPECIAL function codes, instr[5:0]
    localparam logic [funct_w-1:0] fn_sll     = 6'b000000;
    localparam logic [funct_w-1:0] fn_srl     = 6'b000010;
    localparam logic [funct_w-1:0] fn_sra     = 6'b000011;
    localparam logic [funct_w-1:0] fn_sllv    = 6'b000100;
    localparam logic [funct_w-1:0] fn_srlv    = 6'b000110;
    localparam logic [funct_w-1:0] fn_srav    = 6'b000111;
    localparam logic [funct_w-1:0] fn_jr      = 6'b001000;
    localparam logic [funct_w-1:0] fn_jalr    = 6'b001001;
    localparam logic [funct_w-1:0] fn_syscall = 6'b001100;
    localparam logic [funct_w-1:0] fn_break   = 6'b001101;
    localparam logic [funct_w-1:0] fn_add     = 6'b100000;
    localparam logic [funct_w-1:0] fn_addu    = 6'b100001;
    localparam logic [funct_w-1:0] fn_sub     = 6'b100010;
    localparam logic [funct_w-1:0] fn_subu    = 6'b100011;
    localparam logic [funct_w-1:0] fn_and     = 6'b100100;
    localparam logic [funct_w-1:0] fn_or      = 6'b100101;
    localparam logic [funct_w-1:0] fn_xor     = 6'b100110;
    localparam logic [funct_w-1:0] fn_nor     = 6'b100111;
    localparam logic [funct_w-1:0] fn_slt     = 6'b101010;
    localparam logic [funct_w-1:0] fn_sltu    = 6'b101011;

    // REGIMM branch selects, instr[20:16]
    localparam logic [rt_w-1:0] rt_bltz   = 5'b00000;
    localparam logic [rt_w-1:0] rt_bgez   = 5'b00001;
    localparam logic [rt_w-1:0] rt_bltzal = 5'b10000;
    localparam logic [rt_w-1:0] rt_bgezal = 5'b10001;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor, alu_or, alu_xor
    } alu_func_e;

    typedef enum logic [1:0] {
        sft_lui, sft_sll, sft_sra, sft_srl
    } sft_func_e;

    typedef enum logic [2:0] {
        br_beq, br_bne, br_bgez, br_bgtz, br_blez, br_bltz, br_bgezal, br_bltzal
    } branch_e;

    typedef enum logic [1:0] {
        jmp_j, jmp_jr, jmp_jal, jmp_jalr
    } jump_e;

    typedef enum logic {
        out_alu, out_sft
    } out_sel_e;

    typedef enum logic [1:0] {
        dst_rt  = 2'd0,
        dst_rd  = 2'd1,
        dst_r31 = 2'd2
    } regdst_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    typedef struct packed {
        alu_func_e alu_func;
        sft_func_e sft_func;
        out_sel_e  out_sel;
        logic      alu_srcb_sel_rt;
        logic      sft_srcb_sel_rs;
        logic      sft_srca_sel_imm;
        logic      imm_sign;
        logic      intovf_en;
    } alu_ctrl_t;

    typedef struct packed {
        branch_e branch;
        jump_e   jump;
        logic    isbranch;
        logic    isjump;
        logic    link;
    } flow_ctrl_t;

    typedef struct packed {
        logic      memreq;
        logic      memwr;
        mem_size_e size;
        logic      rdata_sign;
        logic      memtoreg;
    } mem_ctrl_t;

    typedef struct packed {
        logic    regwrite;
        regdst_e regdst;
        logic    syscall;
        logic    mips_break;
        logic    reserved_instr;
    } wb_ctrl_t;

endpackage

//--- verilog/alu_decode.sv
`timescale 1ns/1ps

module alu_decode (
    input  logic [decode_pkg::op_w-1:0]    op,
    input  logic [decode_pkg::funct_w-1:0] funct,
    output decode_pkg::alu_ctrl_t          ctrl
);
    import decode_pkg::*;

    always_comb
    begin
        ctrl.alu_func         = alu_add;
        ctrl.sft_func         = sft_lui;
        ctrl.out_sel          = out_alu;
        ctrl.alu_srcb_sel_rt  = 1'b0;
        ctrl.sft_srcb_sel_rs  = 1'b0;
        ctrl.sft_srca_sel_imm = 1'b0;
        ctrl.imm_sign         = 1'b0;
        ctrl.intovf_en        = 1'b0;

        case (op)
            op_special:
            begin
                case (funct)
                    fn_add, fn_sub:
                    begin
                        ctrl.alu_func        = (funct == fn_sub) ? alu_sub : alu_add;
                        ctrl.alu_srcb_sel_rt = 1'b1;
                        ctrl.intovf_en       = 1'b1; // Trapping forms only
                    end
                    fn_addu, fn_subu:
                    begin
                        ctrl.alu_func        = (funct == fn_subu) ? alu_sub : alu_add;
                        ctrl.alu_srcb_sel_rt = 1'b1;
                    end
                    fn_slt, fn_sltu, fn_and, fn_or, fn_xor, fn_nor:
                    begin
                        ctrl.alu_srcb_sel_rt = 1'b1;
                        case (funct)
                            fn_slt:  ctrl.alu_func = alu_slt;
                            fn_sltu: ctrl.alu_func = alu_sltu;
                            fn_and:  ctrl.alu_func = alu_and;
                            fn_or:   ctrl.alu_func = alu_or;
                            fn_xor:  ctrl.alu_func = alu_xor;
                            default: ctrl.alu_func = alu_nor;
                        endcase
                    end
                    fn_sll, fn_sllv, fn_sra, fn_srav, fn_srl, fn_srlv:
                    begin
                        ctrl.out_sel         = out_sft;
                        ctrl.sft_srcb_sel_rs = funct[2]; // Variable forms take amount from rs
                        case (funct[1:0])
                            2'b00:   ctrl.sft_func = sft_sll;
                            2'b11:   ctrl.sft_func = sft_sra;
                            default: ctrl.sft_func = sft_srl;
                        endcase
                    end
                    default: ;
                endcase
            end
            op_addi:
            begin
                ctrl.imm_sign  = 1'b1;
                ctrl.intovf_en = 1'b1;
            end
            op_addiu, op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw:
                ctrl.imm_sign = 1'b1; // Address add for memory ops
            op_slti:
            begin
                ctrl.alu_func = alu_slt;
                ctrl.imm_sign = 1'b1;
            end
            op_sltiu:
            begin
                ctrl.alu_func = alu_sltu;
                ctrl.imm_sign = 1'b1;
            end
            op_andi: ctrl.alu_func = alu_and;
            op_ori:  ctrl.alu_func = alu_or;
            op_xori: ctrl.alu_func = alu_xor;
            op_lui:
            begin
                ctrl.out_sel          = out_sft;
                ctrl.sft_srca_sel_imm = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/flow_decode.sv
`timescale 1ns/1ps

module flow_decode (
    input  logic [decode_pkg::op_w-1:0]    op,
    input  logic [decode_pkg::funct_w-1:0] funct,
    input  logic [decode_pkg::rt_w-1:0]    rt,
    output decode_pkg::flow_ctrl_t         ctrl
);
    import decode_pkg::*;

    always_comb
    begin
        ctrl.branch   = br_beq;
        ctrl.jump     = jmp_j;
        ctrl.isbranch = 1'b0;
        ctrl.isjump   = 1'b0;
        ctrl.link     = 1'b0;

        case (op)
            op_special:
            begin
                if (funct == fn_jr)
                begin
                    ctrl.jump   = jmp_jr;
                    ctrl.isjump = 1'b1;
                end
                else if (funct == fn_jalr)
                begin
                    ctrl.jump   = jmp_jalr;
                    ctrl.isjump = 1'b1;
                    ctrl.link   = 1'b1;
                end
            end
            op_regimm:
            begin
                ctrl.isbranch = 1'b1; // Unknown rt still flagged, branch stays 0
                case (rt)
                    rt_bltz: ctrl.branch = br_bltz;
                    rt_bgez: ctrl.branch = br_bgez;
                    rt_bltzal:
                    begin
                        ctrl.branch = br_bltzal;
                        ctrl.link   = 1'b1;
                    end
                    rt_bgezal:
                    begin
                        ctrl.branch = br_bgezal;
                        ctrl.link   = 1'b1;
                    end
                    default: ;
                endcase
            end
            op_j:
                ctrl.isjump = 1'b1;
            op_jal:
            begin
                ctrl.jump   = jmp_jal;
                ctrl.isjump = 1'b1;
                ctrl.link   = 1'b1;
            end
            op_beq:  ctrl.isbranch = 1'b1;
            op_bne:
            begin
                ctrl.branch   = br_bne;
                ctrl.isbranch = 1'b1;
            end
            op_blez:
            begin
                ctrl.branch   = br_blez;
                ctrl.isbranch = 1'b1;
            end
            op_bgtz:
            begin
                ctrl.branch   = br_bgtz;
                ctrl.isbranch = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/mem_decode.sv
`timescale 1ns/1ps

module mem_decode (
    input  logic [decode_pkg::op_w-1:0] op,
    output decode_pkg::mem_ctrl_t       ctrl
);
    import decode_pkg::*;

    always_comb
    begin
        ctrl.memreq     = 1'b0;
        ctrl.memwr      = 1'b0;
        ctrl.size       = size_byte;
        ctrl.rdata_sign = 1'b0;
        ctrl.memtoreg   = 1'b0;

        case (op)
            op_lb, op_lh, op_lw:
            begin
                ctrl.memreq     = 1'b1;
                ctrl.rdata_sign = 1'b1;
                ctrl.memtoreg   = 1'b1;
            end
            op_lbu, op_lhu:
            begin
                ctrl.memreq   = 1'b1;
                ctrl.memtoreg = 1'b1;
            end
            op_sb, op_sh, op_sw:
            begin
                ctrl.memreq = 1'b1;
                ctrl.memwr  = 1'b1;
            end
            default: ;
        endcase

        case (op)
            op_lh, op_lhu, op_sh: ctrl.size = size_half;
            op_lw, op_sw:         ctrl.size = size_word;
            default:              ctrl.size = size_byte; // Also byte ops
        endcase
    end

endmodule

//--- verilog/wb_decode.sv
`timescale 1ns/1ps

module wb_decode (
    input  logic [decode_pkg::op_w-1:0]    op,
    input  logic [decode_pkg::funct_w-1:0] funct,
    input  logic [decode_pkg::rt_w-1:0]    rt,
    output decode_pkg::wb_ctrl_t           ctrl
);
    import decode_pkg::*;

    always_comb
    begin
        ctrl.regwrite       = 1'b0;
        ctrl.regdst         = dst_rt;
        ctrl.syscall        = 1'b0;
        ctrl.mips_break     = 1'b0;
        ctrl.reserved_instr = 1'b0;

        case (op)
            op_special:
            begin
                case (funct)
                    fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu,
                    fn_and, fn_or, fn_xor, fn_nor,
                    fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav,
                    fn_jalr:
                    begin
                        ctrl.regwrite = 1'b1;
                        ctrl.regdst   = dst_rd;
                    end
                    fn_jr:      ;
                    fn_syscall: ctrl.syscall    = 1'b1;
                    fn_break:   ctrl.mips_break = 1'b1;
                    default:    ctrl.reserved_instr = 1'b1; // Includes mul/div and hi/lo
                endcase
            end
            op_regimm:
            begin
                case (rt)
                    rt_bltzal, rt_bgezal:
                    begin
                        ctrl.regwrite = 1'b1;
                        ctrl.regdst   = dst_r31;
                    end
                    rt_bltz, rt_bgez: ;
                    default: ctrl.reserved_instr = 1'b1;
                endcase
            end
            op_jal:
            begin
                ctrl.regwrite = 1'b1;
                ctrl.regdst   = dst_r31;
            end
            op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui,
            op_lb, op_lh, op_lw, op_lbu, op_lhu:
                ctrl.regwrite = 1'b1;
            op_j, op_beq, op_bne, op_blez, op_bgtz, op_sb, op_sh, op_sw: ;
            default:
                ctrl.reserved_instr = 1'b1; // COP0 lands here too
        endcase
    end

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [decode_pkg::instr_w-1:0]    instr,
    input  logic                              stall,
    input  logic                              flush,
    output decode_pkg::alu_func_e             alu_func,
    output decode_pkg::sft_func_e             sft_func,
    output decode_pkg::out_sel_e              out_sel,
    output logic                              alu_srcb_sel_rt,
    output logic                              sft_srcb_sel_rs,
    output logic                              sft_srca_sel_imm,
    output logic                              imm_sign,
    output logic                              intovf_en,
    output decode_pkg::branch_e               branch,
    output decode_pkg::jump_e                 jump,
    output logic                              isbranch,
    output logic                              isjump,
    output logic                              link,
    output logic                              memreq,
    output logic                              memwr,
    output decode_pkg::mem_size_e             size,
    output logic                              rdata_sign,
    output logic                              memtoreg,
    output logic                              regwrite,
    output decode_pkg::regdst_e               regdst,
    output logic                              syscall,
    output logic                              mips_break,
    output logic                              reserved_instr
);
    import decode_pkg::*;

    logic [op_w-1:0]    op;
    logic [rt_w-1:0]    rt;
    logic [funct_w-1:0] funct;

    alu_ctrl_t  alu_d, alu_q;
    flow_ctrl_t flow_d, flow_q;
    mem_ctrl_t  mem_d, mem_q;
    wb_ctrl_t   wb_d, wb_q;

    assign op    = instr[31:26];
    assign rt    = instr[20:16];
    assign funct = instr[5:0];

    alu_decode alu_decode_inst (.op(op), .funct(funct), .ctrl(alu_d));

    flow_decode flow_decode_inst (.op(op), .funct(funct), .rt(rt), .ctrl(flow_d));

    mem_decode mem_decode_inst (.op(op), .ctrl(mem_d));

    wb_decode wb_decode_inst (.op(op), .funct(funct), .rt(rt), .ctrl(wb_d));

    // Flush wins over stall
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            alu_q  <= '0;
            flow_q <= '0;
            mem_q  <= '0;
            wb_q   <= '0;
        end
        else if (flush)
        begin
            alu_q  <= '0; // Bubble
            flow_q <= '0;
            mem_q  <= '0;
            wb_q   <= '0;
        end
        else if (!stall)
        begin
            alu_q  <= alu_d;
            flow_q <= flow_d;
            mem_q  <= mem_d;
            wb_q   <= wb_d;
        end
    end

    assign alu_func         = alu_q.alu_func;
    assign sft_func         = alu_q.sft_func;
    assign out_sel          = alu_q.out_sel;
    assign alu_srcb_sel_rt  = alu_q.alu_srcb_sel_rt;
    assign sft_srcb_sel_rs  = alu_q.sft_srcb_sel_rs;
    assign sft_srca_sel_imm = alu_q.sft_srca_sel_imm;
    assign imm_sign         = alu_q.imm_sign;
    assign intovf_en        = alu_q.intovf_en;
    assign branch           = flow_q.branch;
    assign jump             = flow_q.jump;
    assign isbranch         = flow_q.isbranch;
    assign isjump           = flow_q.isjump;
    assign link             = flow_q.link;
    assign memreq           = mem_q.memreq;
    assign memwr            = mem_q.memwr;
    assign size             = mem_q.size;
    assign rdata_sign       = mem_q.rdata_sign;
    assign memtoreg         = mem_q.memtoreg;
    assign regwrite         = wb_q.regwrite;
    assign regdst           = wb_q.regdst;
    assign syscall          = wb_q.syscall;
    assign mips_break       = wb_q.mips_break;
    assign reserved_instr   = wb_q.reserved_instr;

endmodule

//--- dv/decode_stage_asserts.sv
`timescale 1ns/1ps

module decode_stage_asserts (
    input logic        clk,
    input logic        rst_n,
    input logic        stall,
    input logic        flush,
    input logic        regwrite,
    input logic        memreq,
    input logic        isbranch,
    input logic        reserved_instr,
    input logic [30:0] ctrl_word
);
    int unsigned fail_count = 0;

    flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !regwrite && !memreq && !isbranch)
        else
        begin
            fail_count++;
            $error("flush did not leave a bubble");
        end

    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall && !flush |=> $stable(ctrl_word)) // Flush overrides stall
        else
        begin
            fail_count++;
            $error("control word changed during stall");
        end

    reserved_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        reserved_instr |-> !regwrite)
        else
        begin
            fail_count++;
            $error("reserved instruction writes a register");
        end

endmodule

bind decode_stage decode_stage_asserts asserts_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .stall          (stall),
    .flush          (flush),
    .regwrite       (regwrite),
    .memreq         (memreq),
    .isbranch       (isbranch),
    .reserved_instr (reserved_instr),
    .ctrl_word      ({alu_q, flow_q, mem_q, wb_q})
);

//--- dv/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;
    import decode_pkg::*;

    typedef struct packed {
        alu_ctrl_t  a;
        flow_ctrl_t f;
        mem_ctrl_t  m;
        wb_ctrl_t   w;
    } ctrl_t;

    localparam int total_cycles = 460; // Upper bound over all tests

    logic [5:0] kept_fn [20] = '{fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav, fn_jr,
        fn_jalr, fn_syscall, fn_break, fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or,
        fn_xor, fn_nor, fn_slt, fn_sltu};
    logic [4:0] kept_rt [4] = '{rt_bltz, rt_bgez, rt_bltzal, rt_bgezal};
    logic [5:0] kept_op [22] = '{op_j, op_jal, op_beq, op_bne, op_blez, op_bgtz, op_addi,
        op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui, op_lb, op_lh, op_lw,
        op_lbu, op_lhu, op_sb, op_sh, op_sw};
    // ERET, MULT, DIV, MFHI
    logic [31:0] extra_w [4] = '{32'h4200_0018, 32'h0085_0018, 32'h0085_001a, 32'h0000_1010};

    logic               clk;
    logic               rst_n;
    logic [instr_w-1:0] instr;
    logic               stall;
    logic               flush;
    alu_func_e          alu_func;
    sft_func_e          sft_func;
    out_sel_e           out_sel;
    branch_e            branch;
    jump_e              jump;
    mem_size_e          size;
    regdst_e            regdst;
    logic alu_srcb_sel_rt, sft_srcb_sel_rs, sft_srca_sel_imm, imm_sign, intovf_en;
    logic isbranch, isjump, link, memreq, memwr, rdata_sign, memtoreg;
    logic regwrite, syscall, mips_break, reserved_instr;

    ctrl_t act;
    ctrl_t exp_q = '0;
    string test_name = "reset";
    int    checks = 0;
    int    errors = 0;
    int    chk0 = 0;
    int    err0 = 0;

    decode_stage decode_stage_inst (.*);

    assign act = {alu_func, sft_func, out_sel, alu_srcb_sel_rt, sft_srcb_sel_rs,
        sft_srca_sel_imm, imm_sign, intovf_en, branch, jump, isbranch, isjump, link,
        memreq, memwr, size, rdata_sign, memtoreg, regwrite, regdst, syscall, mips_break,
        reserved_instr};

    function automatic bit is_kept(input logic [instr_w-1:0] w);
        bit hit;
        hit = 1'b0;
        foreach (kept_op[i]) hit |= (w[31:26] == kept_op[i]);
        foreach (kept_fn[i]) hit |= (w[31:26] == op_special && w[5:0] == kept_fn[i]);
        foreach (kept_rt[i]) hit |= (w[31:26] == op_regimm && w[20:16] == kept_rt[i]);
        return hit;
    endfunction

    function automatic ctrl_t ref_decode(input logic [instr_w-1:0] w);
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] rt;
        logic sp, ri, r_alu, shift, ld, st, al;
        ctrl_t c;
        op = w[31:26];
        fn = w[5:0];
        rt = w[20:16];
        sp = (op == op_special);
        ri = (op == op_regimm);
        r_alu = sp && (fn inside {fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu, fn_and,
            fn_or, fn_xor, fn_nor});
        shift = sp && (fn inside {fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav});
        ld = op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
        st = op inside {op_sb, op_sh, op_sw};
        al = ri && (rt inside {rt_bgezal, rt_bltzal}); // Linking branches
        c = '0;
        if (sp && fn inside {fn_sub, fn_subu}) c.a.alu_func = alu_sub;
        if ((sp && fn == fn_slt) || op == op_slti) c.a.alu_func = alu_slt;
        if ((sp && fn == fn_sltu) || op == op_sltiu) c.a.alu_func = alu_sltu;
        if ((sp && fn == fn_and) || op == op_andi) c.a.alu_func = alu_and;
        if ((sp && fn == fn_or) || op == op_ori) c.a.alu_func = alu_or;
        if ((sp && fn == fn_xor) || op == op_xori) c.a.alu_func = alu_xor;
        if (sp && fn == fn_nor) c.a.alu_func = alu_nor;
        if (sp && fn inside {fn_sll, fn_sllv}) c.a.sft_func = sft_sll;
        if (sp && fn inside {fn_sra, fn_srav}) c.a.sft_func = sft_sra;
        if (sp && fn inside {fn_srl, fn_srlv}) c.a.sft_func = sft_srl;
        c.a.out_sel = (shift || op == op_lui) ? out_sft : out_alu;
        c.a.alu_srcb_sel_rt = r_alu;
        c.a.sft_srcb_sel_rs = sp && (fn inside {fn_sllv, fn_srlv, fn_srav});
        c.a.sft_srca_sel_imm = (op == op_lui);
        c.a.imm_sign = ld || st || (op inside {op_addi, op_addiu, op_slti, op_sltiu});
        c.a.intovf_en = (op == op_addi) || (sp && fn inside {fn_add, fn_sub});
        c.f.isbranch = ri || (op inside {op_beq, op_bne, op_blez, op_bgtz});
        if (op == op_bne) c.f.branch = br_bne;
        if (op == op_blez) c.f.branch = br_blez;
        if (op == op_bgtz) c.f.branch = br_bgtz;
        if (ri && rt == rt_bgez) c.f.branch = br_bgez;
        if (ri && rt == rt_bltz) c.f.branch = br_bltz;
        if (ri && rt == rt_bgezal) c.f.branch = br_bgezal;
        if (ri && rt == rt_bltzal) c.f.branch = br_bltzal;
        c.f.isjump = (op inside {op_j, op_jal}) || (sp && fn inside {fn_jr, fn_jalr});
        if (op == op_jal) c.f.jump = jmp_jal;
        if (sp && fn == fn_jr) c.f.jump = jmp_jr;
        if (sp && fn == fn_jalr) c.f.jump = jmp_jalr;
        c.f.link = al || op == op_jal || (sp && fn == fn_jalr);
        c.m.memreq = ld || st;
        c.m.memwr = st;
        if (op inside {op_lh, op_lhu, op_sh}) c.m.size = size_half;
        if (op inside {op_lw, op_sw}) c.m.size = size_word;
        c.m.rdata_sign = op inside {op_lb, op_lh, op_lw};
        c.m.memtoreg = ld;
        c.w.regwrite = r_alu || shift || ld || c.f.link
            || (op inside {op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui});
        if (r_alu || shift || (sp && fn == fn_jalr)) c.w.regdst = dst_rd;
        if (al || op == op_jal) c.w.regdst = dst_r31;
        c.w.syscall = sp && fn == fn_syscall;
        c.w.mips_break = sp && fn == fn_break;
        c.w.reserved_instr = !is_kept(w);
        return c;
    endfunction

    // Indices 0-19 SPECIAL, 20-23 REGIMM, 24-45 other opcodes
    function automatic logic [instr_w-1:0] kept_word(input int idx);
        logic [instr_w-1:0] w;
        w = $urandom; // Random rs, rt, rd, shamt and immediate
        if (idx < 20)
            w = {op_special, w[25:6], kept_fn[idx]};
        else if (idx < 24)
            w = {op_regimm, w[25:21], kept_rt[idx-20], w[15:0]};
        else
            w[31:26] = kept_op[idx-24];
        return w;
    endfunction

    task automatic drive(input logic [instr_w-1:0] w, input logic s, input logic f);
        @(posedge clk);
        #1;
        instr = w;
        stall = s;
        flush = f;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        chk0 = checks;
        err0 = errors;
    endtask

    task automatic finish_test();
        @(posedge clk);
        @(negedge clk);
        $display("%s: %0d checks, %0d errors", test_name, checks - chk0, errors - err0);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Expected decode register
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            exp_q <= '0;
        else if (flush)
            exp_q <= '0;
        else if (!stall)
            exp_q <= ref_decode(instr);
    end

    always @(negedge clk)
    begin
        if (rst_n)
        begin
            checks++;
            if (act !== exp_q)
            begin
                errors++;
                $display("ERROR %s: expected %h actual %h", test_name, exp_q, act);
            end
        end
    end

    initial
    begin
        #(total_cycles * 10 * 2);
        $display("Timeout: tests did not finish within %0d cycles", total_cycles * 2);
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        logic [instr_w-1:0] w;
        int unsigned seed;
        int n;
        seed = $urandom(32'h7fb2_9e06);
        rst_n = 1'b0;
        instr = '0;
        stall = 1'b1; // Keeps zero after reset until first load
        flush = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (act !== '0)
        begin
            errors++;
            $display("ERROR %s: expected %h actual %h", test_name, 31'h0, act);
        end
        finish_test();

        start_test("directed");
        for (int i = 0; i < 46; i++)
            drive(kept_word(i), 1'b0, 1'b0);
        finish_test();

        start_test("reserved");
        for (int i = 0; i < 24; i++)
        begin
            if (i < 4)
                w = extra_w[i];
            else
            begin
                do
                begin
                    w = $urandom;
                    if (i % 3 == 1)
                        w[31:26] = op_special;
                    if (i % 3 == 2)
                        w[31:26] = op_regimm;
                end
                while (is_kept(w));
            end
            drive(w, 1'b0, 1'b0);
            @(posedge clk);
            @(negedge clk);
            if (reserved_instr !== 1'b1 || regwrite !== 1'b0)
            begin
                errors++;
                $display("ERROR %s: expected reserved=1 regwrite=0 actual reserved=%b regwrite=%b",
                    test_name, reserved_instr, regwrite);
            end
        end
        finish_test();

        start_test("stall");
        w = kept_word($urandom_range(45, 0));
        drive(w, 1'b0, 1'b0);
        n = $urandom_range(8, 3);
        for (int i = 0; i < n; i++)
            drive($urandom, 1'b1, 1'b0);
        @(posedge clk);
        @(negedge clk);
        if (act !== ref_decode(w))
        begin
            errors++;
            $display("ERROR %s: expected %h actual %h", test_name, ref_decode(w), act);
        end
        finish_test();

        start_test("flush");
        for (int i = 0; i < 2; i++)
        begin
            drive(kept_word($urandom_range(45, 0)), 1'b0, 1'b0);
            drive($urandom, i == 1, 1'b1); // Second pass also stalls
            @(posedge clk);
            @(negedge clk);
            if (act !== '0)
            begin
                errors++;
                $display("ERROR %s: expected %h actual %h", test_name, 31'h0, act);
            end
        end
        finish_test();

        start_test("random");
        for (int i = 0; i < 300; i++)
        begin
            w = ($urandom_range(1, 0) == 1) ? kept_word($urandom_range(45, 0)) : $urandom;
            drive(w, $urandom_range(4, 0) == 0, $urandom_range(9, 0) == 0);
        end
        finish_test();

        errors += decode_stage_inst.asserts_inst.fail_count;
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- list.f
verilog/decode_pkg.sv
verilog/alu_decode.sv
verilog/flow_decode.sv
verilog/mem_decode.sv
verilog/wb_decode.sv
verilog/decode_stage.sv
dv/decode_stage_asserts.sv
dv/decode_stage_tb.sv
